/* bench/spi_reg_checker.sv */
`timescale 1ns/1ns

// Cycle rules of the two-stage command sequencer
module spi_reg_checker #(
  parameter int REG_COUNT = 8
) (
  input logic       clk,
  input logic       resetn,
  input logic       frame_strobe,
  input logic [7:0] frame_op,      // Opcode field of the assembled frame
  input logic [7:0] frame_addr,    // Address field of the assembled frame
  input logic       req_strobe,
  input logic       req_wr_en,
  input logic       evt_done
);

  import spi_reg_pkg::*;

  logic cmd_valid;   // Write or read with an address below REG_COUNT
  logic rejected;    // Complete frame that must not reach the bank
  logic good_write;  // Complete frame allowed to write

  assign cmd_valid  = ((frame_op == OP_WRITE) || (frame_op == OP_READ)) &&
                      (frame_addr < REG_COUNT);
  assign rejected   = frame_strobe & ~cmd_valid;
  assign good_write = frame_strobe && cmd_valid && (frame_op == OP_WRITE);

  // Bank request only one cycle after an accepted frame
  a_req_after_frame: assert property (@(posedge clk) disable iff (resetn)
    req_strobe |-> $past(frame_strobe && cmd_valid))
    else $error("req_strobe without an accepted frame one cycle before");

  // Accepted frame always yields a request
  a_frame_gives_req: assert property (@(posedge clk) disable iff (resetn)
    (frame_strobe && cmd_valid) |=> req_strobe)
    else $error("Accepted frame did not issue req_strobe");

  // Done one cycle after the request, or after the rejected frame's stage 1
  a_done_follows: assert property (@(posedge clk) disable iff (resetn)
    (req_strobe || $past(rejected)) |=> evt_done)
    else $error("cmd_evt.done missing one cycle after stage 1");

  a_done_source: assert property (@(posedge clk) disable iff (resetn)
    evt_done |-> ($past(req_strobe) || $past(rejected, 2)))
    else $error("cmd_evt.done without a command behind it");

  // Writes only come from valid write frames
  a_no_bad_write: assert property (@(posedge clk) disable iff (resetn)
    (req_strobe && req_wr_en) |-> $past(good_write))
    else $error("Write request issued for an invalid command");

endmodule

bind spi_cmd_ctrl spi_reg_checker #(
  .REG_COUNT (REG_COUNT)
) i_checker (
  .clk          (clk),
  .resetn       (resetn),
  .frame_strobe (frame_strobe),
  .frame_op     (frame.frame_cmd.opcode),
  .frame_addr   (frame.frame_cmd.addr),
  .req_strobe   (req_strobe),
  .req_wr_en    (reg_req.wr_en),
  .evt_done     (cmd_evt.done)
);

/* bench/spi_reg_tb.sv */
`timescale 1ns/1ns

module spi_reg_tb;

  import spi_reg_pkg::*;

  localparam int REG_COUNT = 8;
  localparam int HALF      = 4;   // SCK half-period in clk
  localparam int GAP       = 8;   // Idle clk between frames
  localparam int N_FRAMES  = 3 + (2 * REG_COUNT + 1) + 5 + (REG_COUNT + 5) + 4;
  localparam int LIMIT     = N_FRAMES * 600 + 2000;

  logic        clk;
  logic        resetn;
  logic        sck;
  logic        cs_n;
  logic        copi;
  logic        cipo;
  logic [31:0] cfg_word;
  cmd_evt_t    cmd_evt;

  logic [31:0] rng_state;
  logic [31:0] model_regs [REG_COUNT];  // Reference register file
  logic [15:0] model_seq;
  logic [63:0] pending_resp;            // Expected on the next frame

  logic [63:0] exp_resp_q [$];
  logic [63:0] got_q [$];
  logic [16:0] exp_evt_q [$];
  logic [31:0] exp_cfg_q [$];

  string       cur_test;
  int          err_cnt;
  int          check_cnt;
  int          test_err_start;
  int          cycle_cnt;
  logic [63:0] exp_r;
  logic [63:0] got_r;
  logic [16:0] exp_e;
  logic [16:0] got_e;
  logic [31:0] exp_c;
  int          order [REG_COUNT];
  logic [31:0] val;
  logic [63:0] junk;

  spi_reg_top #(
    .REG_COUNT (REG_COUNT)
  ) i_dut (
    .clk      (clk),
    .resetn   (resetn),
    .sck      (sck),
    .cs_n     (cs_n),
    .copi     (copi),
    .cipo     (cipo),
    .cfg_word (cfg_word),
    .cmd_evt  (cmd_evt)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // Reserved bytes get random filler, the DUT must ignore them
  function automatic logic [63:0] make_cmd(input logic [7:0] op, input logic [7:0] addr,
                                           input logic [31:0] data);
    logic [31:0] filler;
    filler = next_rand();
    return {data, filler[15:0], addr, op};
  endfunction

  // Position in the 64-bit word of wire bit k, bytes LSB first and bits MSB first
  function automatic int wire_bit(input int k);
    return (k / 8) * 8 + 7 - (k % 8);
  endfunction

  // Expected response, event and cfg_word for one command
  function automatic void ref_response(input logic [63:0] cmd, output logic [63:0] resp,
                                       output logic [16:0] evt, output logic [31:0] cfg);
    logic [7:0]  op;
    logic [7:0]  addr;
    logic [31:0] data;
    logic [7:0]  status;
    logic [31:0] rd;
    logic        access;
    op     = cmd[7:0];
    addr   = cmd[15:8];
    data   = cmd[63:32];
    access = (op == OP_WRITE) || (op == OP_READ);
    rd     = 32'h0;  // Nop and errors carry no data
    if (op > OP_READ)
      status = ST_BAD_OP;
    else if (access && addr >= REG_COUNT)
      status = ST_BAD_ADDR;
    else
      status = ST_OK;
    if (status == ST_OK && op == OP_WRITE) begin
      model_regs[addr] = data;
      rd               = data;  // Write echoes its value
    end else if (status == ST_OK && op == OP_READ) begin
      rd = model_regs[addr];
    end
    model_seq = model_seq + 16'd1;  // Every completed frame counts
    resp      = {rd, model_seq, addr, status};
    evt       = {1'b1, status != ST_OK, op, addr[6:0]};
    cfg       = model_regs[0];
  endfunction

  // SPI mode 0 host, nbits < 64 leaves the frame unfinished
  task automatic shift_frame(input logic [63:0] tx, input int nbits, output logic [63:0] rx);
    rx = '0;
    @(posedge clk);
    cs_n <= 1'b0;
    copi <= tx[wire_bit(0)];
    for (int k = 0; k < nbits; k++) begin
      repeat (HALF - 1) @(posedge clk);
      @(negedge clk);
      rx[wire_bit(k)] = cipo;  // Host samples at the rising SCK
      @(posedge clk);
      sck <= 1'b1;
      repeat (HALF) @(posedge clk);
      sck <= 1'b0;
      if (k < nbits - 1)
        copi <= tx[wire_bit(k + 1)];
    end
    repeat (HALF) @(posedge clk);
    cs_n <= 1'b1;
    repeat (GAP) @(posedge clk);
  endtask

  task automatic run_frame(input logic [63:0] cmd);
    logic [63:0] resp;
    logic [16:0] evt;
    logic [31:0] cfg;
    logic [63:0] got;
    ref_response(cmd, resp, evt, cfg);
    exp_resp_q.push_back(pending_resp);  // This frame returns the previous answer
    pending_resp = resp;
    exp_evt_q.push_back(evt);
    exp_cfg_q.push_back(cfg);
    shift_frame(cmd, 64, got);
    got_q.push_back(got);
  endtask

  task automatic start_test(input string name);
    cur_test       = name;
    test_err_start = err_cnt;
  endtask

  // Waits for outstanding events and captured frames to be compared
  task automatic finish_test();
    int waited;
    waited = 0;
    while ((exp_evt_q.size() != 0 || got_q.size() != 0) && waited < 32) begin
      @(posedge clk);
      waited++;
    end
    if (exp_evt_q.size() != 0) begin
      $display("%s: cmd_evt.done never came for %0d command(s)", cur_test, exp_evt_q.size());
      err_cnt++;
      exp_evt_q.delete();
      exp_cfg_q.delete();
    end
    if (err_cnt == test_err_start)
      $display("test %s: ok", cur_test);
    else
      $display("test %s: %0d error(s)", cur_test, err_cnt - test_err_start);
  endtask

  // Response comparison
  always @(negedge clk) begin
    if (got_q.size() > 0) begin
      exp_r = exp_resp_q.pop_front();
      got_r = got_q.pop_front();
      check_cnt++;
      if (got_r !== exp_r) begin
        $display("[FAIL] %s response: expected %h, actual %h", cur_test, exp_r, got_r);
        err_cnt++;
      end
    end
  end

  // Event and cfg_word comparison on each done pulse
  always @(negedge clk) begin
    if (!resetn && cmd_evt.done) begin
      if (exp_evt_q.size() == 0) begin
        $display("%s: cmd_evt.done pulsed with no command outstanding", cur_test);
        err_cnt++;
      end else begin
        exp_e = exp_evt_q.pop_front();
        exp_c = exp_cfg_q.pop_front();
        got_e = cmd_evt;
        check_cnt++;
        if (got_e !== exp_e) begin
          $display("[FAIL] %s cmd_evt: expected %h, actual %h", cur_test, exp_e, got_e);
          err_cnt++;
        end
        if (cfg_word !== exp_c) begin
          $display("[FAIL] %s cfg_word: expected %h, actual %h", cur_test, exp_c, cfg_word);
          err_cnt++;
        end
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= LIMIT) begin
      $display("Run stopped after %0d cycles without finishing", cycle_cnt);
      $display("Some tests failed");
      $finish;
    end
  end

  initial begin
    resetn       = 1'b1;  // Reset asserted
    sck          = 1'b0;
    cs_n         = 1'b1;
    copi         = 1'b0;
    rng_state    = 32'hbed067f4;
    model_seq    = '0;
    pending_resp = '0;
    err_cnt      = 0;
    check_cnt    = 0;
    cycle_cnt    = 0;
    cur_test     = "reset";
    for (int i = 0; i < REG_COUNT; i++)
      model_regs[i] = '0;
    repeat (8) @(posedge clk);
    resetn <= 1'b0;
    repeat (4) @(posedge clk);

    start_test("reset_nop");
    run_frame(make_cmd(OP_NOP, 8'h00, 32'h0));  // All-zero reply from reset state
    run_frame(make_cmd(OP_NOP, 8'h00, 32'h0));  // ST_OK with count 1
    if (cfg_word !== 32'h0) begin
      $display("[FAIL] %s cfg_word: expected %h, actual %h", cur_test, 32'h0, cfg_word);
      err_cnt++;
    end
    run_frame(make_cmd(OP_NOP, 8'h00, 32'h0));
    finish_test();

    start_test("write_read");
    for (int i = 0; i < REG_COUNT; i++) begin
      run_frame(make_cmd(OP_WRITE, 8'(i), next_rand()));
      order[i] = i;
    end
    for (int i = REG_COUNT - 1; i > 0; i--) begin  // Shuffle the read order
      int j;
      int t;
      j        = int'(next_rand() % (i + 1));
      t        = order[i];
      order[i] = order[j];
      order[j] = t;
    end
    for (int i = 0; i < REG_COUNT; i++)
      run_frame(make_cmd(OP_READ, 8'(order[i]), next_rand()));
    run_frame(make_cmd(OP_NOP, 8'h00, 32'h0));
    finish_test();

    start_test("cfg_word");
    for (int i = 0; i < 3; i++)
      run_frame(make_cmd(OP_WRITE, 8'h00, next_rand()));  // Checked at each done
    run_frame(make_cmd(OP_READ, 8'h00, 32'h0));
    run_frame(make_cmd(OP_NOP, 8'h00, 32'h0));
    finish_test();

    start_test("bad_cmd");
    run_frame(make_cmd(OP_WRITE, 8'(REG_COUNT + next_rand() % (256 - REG_COUNT)), next_rand()));
    run_frame(make_cmd(OP_READ, 8'(REG_COUNT + next_rand() % (256 - REG_COUNT)), 32'h0));
    run_frame(make_cmd(8'(8'h03 + next_rand() % 253), 8'h00, next_rand()));
    run_frame(make_cmd(8'(8'h03 + next_rand() % 253), 8'h01, next_rand()));
    for (int i = 0; i < REG_COUNT; i++)
      run_frame(make_cmd(OP_READ, 8'(i), 32'h0));  // Contents must be untouched
    run_frame(make_cmd(OP_NOP, 8'h00, 32'h0));
    finish_test();

    start_test("abort");
    val = next_rand();
    run_frame(make_cmd(OP_WRITE, 8'(REG_COUNT - 1), val));
    shift_frame(make_cmd(OP_WRITE, 8'(REG_COUNT - 1), ~val), 24, junk);  // Dropped after 3 bytes
    run_frame(make_cmd(OP_READ, 8'(REG_COUNT - 1), 32'h0));
    run_frame(make_cmd(OP_NOP, 8'h00, 32'h0));
    finish_test();

    $display("checks: %0d, errors: %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

/* hw/spi_byte_port.sv */
`timescale 1ns/1ns

// SPI mode 0 byte engine, all pins resampled into the clk domain
module spi_byte_port (
  input  logic       clk,
  input  logic       resetn,
  input  logic       sck,
  input  logic       cs_n,
  input  logic       copi,
  input  logic [7:0] tx_byte,   // Byte to shift out on cipo
  output logic       cipo,
  output logic [7:0] rx_byte,   // Last byte received
  output logic       rx_strobe, // One clk pulse per received byte
  output logic       cs_active
);

  logic [2:0] sck_sync;   // SCK synchronizer and edge history
  logic [2:0] cs_sync;    // CS synchronizer, active low
  logic [1:0] copi_sync;  // Data lines up with sck_sync[1]
  logic [2:0] rx_cnt;     // Counts up on rising SCK
  logic [2:0] tx_cnt;     // Counts down on falling SCK
  logic       sck_rise;
  logic       sck_fall;

  assign sck_rise  = (sck_sync[2:1] == 2'b01);
  assign sck_fall  = (sck_sync[2:1] == 2'b10);
  assign cs_active = ~cs_sync[2];

  // MSB first; actively driven since nothing else shares the line
  assign cipo = cs_active & tx_byte[tx_cnt];

  always_ff @(posedge clk) begin
    if (resetn) begin
      sck_sync  <= 3'b000;
      cs_sync   <= 3'b111;  // Start deselected
      copi_sync <= 2'b00;
      rx_cnt    <= 3'd0;
      tx_cnt    <= 3'd7;
      rx_strobe <= 1'b0;
    end else begin
      sck_sync  <= {sck_sync[1:0], sck};
      cs_sync   <= {cs_sync[1:0], cs_n};
      copi_sync <= {copi_sync[0], copi};
      rx_strobe <= 1'b0;  // Pulse by default low

      if (cs_active) begin
        if (sck_rise) begin
          rx_cnt    <= rx_cnt + 3'd1;        // Wraps after bit 7
          rx_strobe <= (rx_cnt == 3'd7);     // Eighth bit completes the byte
        end
        if (sck_fall) begin
          tx_cnt <= tx_cnt - 3'd1;           // Wraps back to 7 for the next byte
        end
      end else begin
        // Deselect abandons any partial byte
        rx_cnt <= 3'd0;
        tx_cnt <= 3'd7;
      end
    end
  end

  // Receive shifter
  always_ff @(posedge clk) begin
    if (cs_active && sck_rise) begin
      rx_byte <= {rx_byte[6:0], copi_sync[1]};
    end
  end

endmodule

/* hw/spi_cmd_ctrl.sv */
`timescale 1ns/1ns

// Two-stage command sequencer
// Stage 1 decodes and issues the bank request, stage 2 builds the response
module spi_cmd_ctrl #(
  parameter int REG_COUNT = 8
) (
  input  logic                    clk,
  input  logic                    resetn,
  input  spi_reg_pkg::spi_frame_u frame,
  input  logic                    frame_strobe,
  input  logic [31:0]             rdata,        // Bank data, valid one cycle after req
  output spi_reg_pkg::reg_req_t   reg_req,
  output logic                    req_strobe,
  output spi_reg_pkg::spi_frame_u resp_frame,
  output spi_reg_pkg::cmd_evt_t   cmd_evt
);

  import spi_reg_pkg::*;

  // Decode of the incoming frame
  logic       op_known;
  logic       op_access;   // Write or read, touches the bank
  logic       addr_ok;
  logic [7:0] dec_status;
  logic       dec_access;  // Access that passed all checks

  // Stage 1 context
  logic              s1_valid;
  logic [7:0]        s1_status;
  logic [7:0]        s1_opcode;
  logic [ADDR_W-1:0] s1_addr;
  logic              s1_use_rdata;

  // Stage 2 response state
  logic [7:0]        resp_status;
  logic [ADDR_W-1:0] resp_addr;
  logic              resp_use_rdata;
  logic [SEQ_W-1:0]  seq_cnt;       // Completed frames since reset

  always_comb begin
    op_known  = (frame.frame_cmd.opcode == OP_NOP) ||
                (frame.frame_cmd.opcode == OP_WRITE) ||
                (frame.frame_cmd.opcode == OP_READ);
    op_access = (frame.frame_cmd.opcode == OP_WRITE) ||
                (frame.frame_cmd.opcode == OP_READ);
    addr_ok   = (frame.frame_cmd.addr < REG_COUNT);
    // Opcode error wins over address error; nop ignores the address
    if (!op_known)
      dec_status = ST_BAD_OP;
    else if (op_access && !addr_ok)
      dec_status = ST_BAD_ADDR;
    else
      dec_status = ST_OK;
    dec_access = op_access && (dec_status == ST_OK);
  end

  // Stage 1 control
  always_ff @(posedge clk) begin
    if (resetn) begin
      req_strobe <= 1'b0;
      s1_valid   <= 1'b0;
    end else begin
      req_strobe <= frame_strobe & dec_access;  // Rejected frames never reach the bank
      s1_valid   <= frame_strobe;
    end
  end

  // Stage 1 payload, captured with the frame
  always_ff @(posedge clk) begin
    if (frame_strobe) begin
      reg_req.wr_en <= (frame.frame_cmd.opcode == OP_WRITE);
      reg_req.addr  <= frame.frame_cmd.addr;
      reg_req.wdata <= frame.frame_cmd.data;
      s1_status     <= dec_status;
      s1_opcode     <= frame.frame_cmd.opcode;
      s1_addr       <= frame.frame_cmd.addr;
      s1_use_rdata  <= dec_access;  // Write echo comes back through rdata too
    end
  end

  // Stage 2, response and event
  always_ff @(posedge clk) begin
    if (resetn) begin
      cmd_evt        <= '0;
      resp_status    <= ST_OK;
      resp_addr      <= '0;
      resp_use_rdata <= 1'b0;
      seq_cnt        <= '0;
    end else begin
      cmd_evt.done <= s1_valid;
      if (s1_valid) begin
        cmd_evt.err    <= (s1_status != ST_OK);
        cmd_evt.opcode <= s1_opcode;
        cmd_evt.addr   <= s1_addr[EVT_ADDR_W-1:0];
        resp_status    <= s1_status;
        resp_addr      <= s1_addr;
        resp_use_rdata <= s1_use_rdata;
        seq_cnt        <= seq_cnt + 1'b1;  // Errors count as completed frames
      end
    end
  end

  // Response bytes; rdata holds until the next request, which only follows a new frame
  always_comb begin
    resp_frame.frame_bytes[0]   = resp_status;
    resp_frame.frame_bytes[1]   = resp_addr;
    resp_frame.frame_bytes[3:2] = seq_cnt;
    resp_frame.frame_bytes[7:4] = resp_use_rdata ? rdata : '0;  // Zero for nop and errors
  end

endmodule

/* hw/spi_frame_assembler.sv */
`timescale 1ns/1ns

// Byte to frame packing, and response byte selection for transmit
module spi_frame_assembler (
  input  logic                    clk,
  input  logic                    resetn,
  input  logic [7:0]              rx_byte,
  input  logic                    rx_strobe,
  input  logic                    cs_active,
  input  spi_reg_pkg::spi_frame_u resp_frame,   // Response to the previous command
  output logic [7:0]              tx_byte,
  output spi_reg_pkg::spi_frame_u frame,        // Valid with frame_strobe
  output logic                    frame_strobe
);

  import spi_reg_pkg::*;

  logic [BYTE_IDX_W-1:0] byte_cnt;  // Position within the frame
  logic                  last_byte;

  assign last_byte = (byte_cnt == BYTE_IDX_W'(FRAME_BYTES - 1));

  // Outgoing byte follows the same little-endian order as the command
  assign tx_byte = resp_frame.frame_bytes[byte_cnt];

  always_ff @(posedge clk) begin
    if (resetn) begin
      byte_cnt     <= '0;
      frame_strobe <= 1'b0;
    end else begin
      frame_strobe <= 1'b0;
      if (!cs_active) begin
        byte_cnt <= '0;            // Abort, partial frame dropped
      end else if (rx_strobe) begin
        byte_cnt     <= byte_cnt + 1'b1;  // Rolls to 0 after the last byte
        frame_strobe <= last_byte;
      end
    end
  end

  // New byte enters at the top and walks down, so byte 0 settles lowest
  always_ff @(posedge clk) begin
    if (rx_strobe) begin
      frame.frame_bytes <= {rx_byte, frame.frame_bytes[FRAME_BYTES-1:1]};
    end
  end

endmodule

/* hw/spi_reg_bank.sv */
`timescale 1ns/1ns

// Register file, one write port and one registered read port
module spi_reg_bank #(
  parameter int REG_COUNT = 8
) (
  input  logic                  clk,
  input  logic                  resetn,
  input  spi_reg_pkg::reg_req_t reg_req,
  input  logic                  req_strobe,
  output logic [31:0]           rdata,     // Post-write value of the addressed register
  output logic [31:0]           cfg_word   // Register 0
);

  import spi_reg_pkg::*;

  localparam int IDX_W = (REG_COUNT > 1) ? $clog2(REG_COUNT) : 1;

  logic [DATA_W-1:0] regs [REG_COUNT];
  logic [IDX_W-1:0]  idx;  // Only in-range addresses are ever requested

  assign idx      = reg_req.addr[IDX_W-1:0];
  assign cfg_word = regs[0];

  always_ff @(posedge clk) begin
    if (resetn) begin
      for (int i = 0; i < REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (req_strobe && reg_req.wr_en) begin
      regs[idx] <= reg_req.wdata;
    end
  end

  // Read port, a write returns the value it stores
  always_ff @(posedge clk) begin
    if (req_strobe) begin
      rdata <= reg_req.wr_en ? reg_req.wdata : regs[idx];
    end
  end

endmodule

/* hw/spi_reg_pkg.sv */
package spi_reg_pkg;

  // Frame geometry
  localparam int FRAME_BYTES = 8;                    // Bytes per SPI frame
  localparam int BYTE_W      = 8;
  localparam int BYTE_IDX_W  = $clog2(FRAME_BYTES);  // Byte counter width
  localparam int ADDR_W      = 8;
  localparam int DATA_W      = 32;
  localparam int SEQ_W       = 16;                   // Command sequence count
  localparam int EVT_ADDR_W  = 7;                    // Enough for up to 128 registers

  // Opcodes, carried in byte 0 of a command frame
  localparam logic [7:0] OP_NOP   = 8'h00;
  localparam logic [7:0] OP_WRITE = 8'h01;
  localparam logic [7:0] OP_READ  = 8'h02;

  // Status codes, returned in byte 0 of the response frame
  localparam logic [7:0] ST_OK       = 8'h00;
  localparam logic [7:0] ST_BAD_ADDR = 8'he1;  // Address not below REG_COUNT
  localparam logic [7:0] ST_BAD_OP   = 8'he2;  // Unknown opcode

  // Command view, byte 0 in the low bits
  typedef struct packed {
    logic [DATA_W-1:0] data;    // Bytes 4..7
    logic [15:0]       rsvd;    // Bytes 2..3, ignored on commands
    logic [ADDR_W-1:0] addr;    // Byte 1
    logic [7:0]        opcode;  // Byte 0
  } frame_cmd_t;

  // One 64-bit frame word, seen either as raw bytes or as command fields
  typedef union packed {
    logic [FRAME_BYTES-1:0][BYTE_W-1:0] frame_bytes;  // Index 0 is the first byte on the wire
    frame_cmd_t                         frame_cmd;
  } spi_frame_u;

  // Register bank access request
  typedef struct packed {
    logic              wr_en;  // 1 write, 0 read
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } reg_req_t;

  // Command completion event, 17 bits
  typedef struct packed {
    logic                  done;    // Single-cycle strobe
    logic                  err;     // Status other than ST_OK
    logic [7:0]            opcode;
    logic [EVT_ADDR_W-1:0] addr;
  } cmd_evt_t;

endpackage

/* hw/spi_reg_top.sv */
`timescale 1ns/1ns

// SPI register block, pins in and config word plus command events out
module spi_reg_top #(
  parameter int REG_COUNT = 8
) (
  input  logic                  clk,
  input  logic                  resetn,
  input  logic                  sck,
  input  logic                  cs_n,
  input  logic                  copi,
  output logic                  cipo,
  output logic [31:0]           cfg_word,
  output spi_reg_pkg::cmd_evt_t cmd_evt
);

  import spi_reg_pkg::*;

  logic [7:0]        rx_byte;
  logic              rx_strobe;
  logic              cs_active;
  logic [7:0]        tx_byte;
  spi_frame_u        frame;
  logic              frame_strobe;
  spi_frame_u        resp_frame;
  reg_req_t          reg_req;
  logic              req_strobe;
  logic [DATA_W-1:0] rdata;

  spi_byte_port i_byte_port (
    .clk       (clk),
    .resetn    (resetn),
    .sck       (sck),
    .cs_n      (cs_n),
    .copi      (copi),
    .tx_byte   (tx_byte),
    .cipo      (cipo),
    .rx_byte   (rx_byte),
    .rx_strobe (rx_strobe),
    .cs_active (cs_active)
  );

  spi_frame_assembler i_frame_assembler (
    .clk          (clk),
    .resetn       (resetn),
    .rx_byte      (rx_byte),
    .rx_strobe    (rx_strobe),
    .cs_active    (cs_active),
    .resp_frame   (resp_frame),
    .tx_byte      (tx_byte),
    .frame        (frame),
    .frame_strobe (frame_strobe)
  );

  spi_cmd_ctrl #(
    .REG_COUNT (REG_COUNT)
  ) i_cmd_ctrl (
    .clk          (clk),
    .resetn       (resetn),
    .frame        (frame),
    .frame_strobe (frame_strobe),
    .rdata        (rdata),
    .reg_req      (reg_req),
    .req_strobe   (req_strobe),
    .resp_frame   (resp_frame),
    .cmd_evt      (cmd_evt)
  );

  spi_reg_bank #(
    .REG_COUNT (REG_COUNT)
  ) i_reg_bank (
    .clk        (clk),
    .resetn     (resetn),
    .reg_req    (reg_req),
    .req_strobe (req_strobe),
    .rdata      (rdata),
    .cfg_word   (cfg_word)
  );

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the SPI register block testbench with Verilator
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module spi_reg_tb \
  -f sources.f \
  -o spi_reg_sim

# The log search below decides the result
./obj_dir/spi_reg_sim | tee "$LOG" || true

if grep -q "All tests passed" "$LOG"; then
  echo "Simulation PASSED"
  exit 0
else
  echo "Simulation FAILED"
  exit 1
fi

/* sources.f */
hw/spi_reg_pkg.sv
hw/spi_byte_port.sv
hw/spi_frame_assembler.sv
hw/spi_cmd_ctrl.sv
hw/spi_reg_bank.sv
hw/spi_reg_top.sv
bench/spi_reg_checker.sv
bench/spi_reg_tb.sv
